/* hdl/scope_pkg.sv */
//--------------------------------------
// Shared widths, command codes, sample and settings types of the capture engine
// Every RTL module and the testbench refer to these by scoped name
//--------------------------------------
package scope_pkg;

  localparam int ADDR_BITS     = 13;              // Sample memory address width
  localparam int BUFFER_SIZE   = 1 << ADDR_BITS;  // 8192 entries
  localparam int SAMPLE_BITS   = 8;               // One ADC byte
  localparam int TIMEBASE_BITS = 32;              // Auto mode timeout counter

  typedef logic [ADDR_BITS-1:0] addr_t;

  // Four bytes taken each clock, ch1_a sits in the low byte like the memory layout
  typedef struct packed {
    logic [SAMPLE_BITS-1:0] ch2_b;
    logic [SAMPLE_BITS-1:0] ch2_a;
    logic [SAMPLE_BITS-1:0] ch1_b;
    logic [SAMPLE_BITS-1:0] ch1_a;
  } adc_sample_t;

  // Command codes, kept on the MCU numbering
  typedef enum logic [7:0] {
    CMD_PRETRIGGER   = 8'h0B,
    CMD_TOTAL        = 8'h0C,
    CMD_TIMEBASE     = 8'h0E,
    CMD_TRIG_CHANNEL = 8'h15,
    CMD_TRIG_EDGE    = 8'h16,
    CMD_TRIG_LEVEL   = 8'h17,
    CMD_TRIG_MODE    = 8'h1A,
    CMD_READ_OFFSET  = 8'h1F,
    CMD_READ_SELECT  = 8'h20   // Byte lane for readback, 0 to 3
  } cmd_opcode_e;

  typedef struct packed {
    cmd_opcode_e opcode;
    logic [31:0] data;         // Setting value in the low bits
  } cmd_t;

  typedef struct packed {
    addr_t                    pretrigger;   // Samples kept before the trigger
    addr_t                    total;        // Pretrigger plus post-trigger samples
    logic [TIMEBASE_BITS-1:0] timebase;     // Auto mode timeout limit
    logic [SAMPLE_BITS-1:0]   level;        // Trigger level
    logic                     edge_fall;    // 0 rising, 1 falling
    logic                     channel2;     // 0 channel 1, 1 channel 2
    logic                     normal_mode;  // 0 auto, 1 normal
    logic [1:0]               byte_select;  // ch1_a, ch1_b, ch2_a, ch2_b
  } capture_cfg_t;

  localparam capture_cfg_t CFG_DEFAULT = '{
    pretrigger:  13'd750,
    total:       13'd1500,
    timebase:    '1,
    level:       8'd128,
    edge_fall:   1'b0,
    channel2:    1'b0,
    normal_mode: 1'b0,
    byte_select: 2'd0
  };

  typedef enum logic [1:0] {
    CAP_FILL,    // Filling the pretrigger region
    CAP_ARMED,   // Waiting for an edge
    CAP_POST,    // Filling the post-trigger region
    CAP_DONE     // Writes stopped until reset
  } capture_state_e;

  typedef struct packed {
    logic  done;
    logic  triggered;
    addr_t trigger_address;
  } capture_status_t;

endpackage

/* hdl/scope_config_regs.sv */
//--------------------------------------
// Settings register file of the capture engine
// One word-wide command per setting, always accepted, in effect next cycle
//--------------------------------------
`timescale 1ns/100ps

module scope_config_regs
(
  input  logic                    sample_write_clock,
  input  logic                    sample_system_reset,
  input  scope_pkg::cmd_t         i_cmd,
  input  logic                    i_cmd_valid,
  output scope_pkg::capture_cfg_t o_cfg,
  output logic                    o_offset_load,   // One cycle load strobe for readback
  output scope_pkg::addr_t        o_offset_value
);

  scope_pkg::capture_cfg_t cfg_q;

//--------------------------------------
// Setting registers

  always_ff @(posedge sample_write_clock)
  begin
    if (sample_system_reset)
      cfg_q <= scope_pkg::CFG_DEFAULT;             // Power-on capture settings
    else if (i_cmd_valid)
    begin
      case (i_cmd.opcode)
        scope_pkg::CMD_PRETRIGGER:
          cfg_q.pretrigger <= i_cmd.data[scope_pkg::ADDR_BITS-1:0];
        scope_pkg::CMD_TOTAL:
          cfg_q.total <= i_cmd.data[scope_pkg::ADDR_BITS-1:0];
        scope_pkg::CMD_TIMEBASE:
          cfg_q.timebase <= i_cmd.data[scope_pkg::TIMEBASE_BITS-1:0];
        scope_pkg::CMD_TRIG_CHANNEL:
          cfg_q.channel2 <= i_cmd.data[0];
        scope_pkg::CMD_TRIG_EDGE:
          cfg_q.edge_fall <= i_cmd.data[0];
        scope_pkg::CMD_TRIG_LEVEL:
          cfg_q.level <= i_cmd.data[scope_pkg::SAMPLE_BITS-1:0];
        scope_pkg::CMD_TRIG_MODE:
          cfg_q.normal_mode <= i_cmd.data[0];
        scope_pkg::CMD_READ_SELECT:
          cfg_q.byte_select <= i_cmd.data[1:0];
        default:
          cfg_q <= cfg_q;                          // Offset load goes to readback
      endcase
    end
  end

  assign o_cfg = cfg_q;

//--------------------------------------
// Read offset strobe

  // Loaded by readback on this edge, so the new offset is used next cycle
  assign o_offset_load  = i_cmd_valid && (i_cmd.opcode == scope_pkg::CMD_READ_OFFSET);
  assign o_offset_value = i_cmd.data[scope_pkg::ADDR_BITS-1:0];

  // Host must only send codes from the command table
  a_known_opcode: assert property (
    @(posedge sample_write_clock) disable iff (sample_system_reset)
    i_cmd_valid |-> i_cmd.opcode inside {
      scope_pkg::CMD_PRETRIGGER,   scope_pkg::CMD_TOTAL,
      scope_pkg::CMD_TIMEBASE,     scope_pkg::CMD_TRIG_CHANNEL,
      scope_pkg::CMD_TRIG_EDGE,    scope_pkg::CMD_TRIG_LEVEL,
      scope_pkg::CMD_TRIG_MODE,    scope_pkg::CMD_READ_OFFSET,
      scope_pkg::CMD_READ_SELECT
    }
  ) else $error("Unknown command opcode %h", i_cmd.opcode);

endmodule

/* hdl/sample_ram.sv */
//--------------------------------------
// Circular sample store, 8192 words of four ADC bytes
// Simple dual port, read data one clock after i_rd_en
//--------------------------------------
`timescale 1ns/100ps

module sample_ram
(
  input  logic                   sample_write_clock,
  input  logic                   i_wr_en,
  input  scope_pkg::addr_t       i_wr_addr,
  input  scope_pkg::adc_sample_t i_wr_data,
  input  logic                   i_rd_en,
  input  scope_pkg::addr_t       i_rd_addr,
  output scope_pkg::adc_sample_t o_rd_data
);

  scope_pkg::adc_sample_t mem [scope_pkg::BUFFER_SIZE];

  // Write port, one sample per clock while capturing
  always_ff @(posedge sample_write_clock)
  begin
    if (i_wr_en)
      mem[i_wr_addr] <= i_wr_data;
  end

  // Registered read port
  // Output holds its last word while i_rd_en is low
  always_ff @(posedge sample_write_clock)
  begin
    if (i_rd_en)
      o_rd_data <= mem[i_rd_addr];
  end

endmodule

/* hdl/trigger_detector.sv */
//--------------------------------------
// Edge trigger on the A byte of the selected channel
// Hit in cycle n+1 refers to the sample written at address n
//--------------------------------------
`timescale 1ns/100ps

module trigger_detector
(
  input  logic                    sample_write_clock,
  input  logic                    sample_system_reset,
  input  scope_pkg::adc_sample_t  i_sample,
  input  scope_pkg::addr_t        i_wr_addr,    // Address this sample is written at
  input  scope_pkg::capture_cfg_t i_cfg,
  output logic                    o_hit,        // One cycle edge pulse
  output scope_pkg::addr_t        o_hit_addr
);

  logic [scope_pkg::SAMPLE_BITS-1:0] chan_byte;
  logic [scope_pkg::SAMPLE_BITS-1:0] cur_q;     // Current sample
  logic [scope_pkg::SAMPLE_BITS-1:0] prev_q;    // Sample before it
  scope_pkg::addr_t                  addr_q;    // Address of cur_q
  logic [1:0]                        fill_q;    // Valid bits for cur_q and prev_q
  logic                              cur_below;
  logic                              prev_below;

  assign chan_byte = i_cfg.channel2 ? i_sample.ch2_a : i_sample.ch1_a;

//--------------------------------------
// Sample pipeline

  always_ff @(posedge sample_write_clock)
  begin
    if (sample_system_reset)
      fill_q <= 2'b00;
    else
      fill_q <= {fill_q[0], 1'b1};  // Both set from the second sample on
  end

  always_ff @(posedge sample_write_clock)
  begin
    cur_q  <= chan_byte;
    prev_q <= cur_q;
    addr_q <= i_wr_addr;            // Keeps the address aligned with cur_q
  end

//--------------------------------------
// Edge compare

  assign prev_below = prev_q < i_cfg.level;
  assign cur_below  = cur_q < i_cfg.level;

  // Rising when crossing up to or above level, falling when dropping below it
  assign o_hit = (&fill_q) &&
                 (i_cfg.edge_fall ? (!prev_below && cur_below)
                                  : (prev_below && !cur_below));

  assign o_hit_addr = addr_q;

endmodule

/* hdl/capture_control.sv */
//--------------------------------------
// Capture FSM with write address, post-trigger and time-base counters
// Stops writes once the post-trigger region is full or auto mode times out
//--------------------------------------
`timescale 1ns/100ps

module capture_control
(
  input  logic                       sample_write_clock,
  input  logic                       sample_system_reset,
  input  scope_pkg::capture_cfg_t    i_cfg,
  input  logic                       i_hit,
  input  scope_pkg::addr_t           i_hit_addr,
  output logic                       o_wr_en,
  output scope_pkg::addr_t           o_wr_addr,
  output scope_pkg::capture_status_t o_status
);

  scope_pkg::capture_state_e           state_q;
  scope_pkg::capture_state_e           state_d;
  scope_pkg::addr_t                    wr_addr_q;
  scope_pkg::addr_t                    post_cnt_q;   // Samples written after the trigger
  scope_pkg::addr_t                    post_next;
  scope_pkg::addr_t                    post_target;
  logic [scope_pkg::TIMEBASE_BITS-1:0] tb_cnt_q;
  logic                                triggered_q;
  scope_pkg::addr_t                    trig_addr_q;
  logic                                hit_take;
  logic                                time_stop;

  assign post_target = i_cfg.total - i_cfg.pretrigger;   // Modulo the buffer size
  assign post_next   = post_cnt_q + 1'b1;                // Includes this cycle's write

  assign hit_take  = (state_q == scope_pkg::CAP_ARMED) && i_hit;
  assign time_stop = !i_cfg.normal_mode && (tb_cnt_q > i_cfg.timebase) && !hit_take &&
                     ((state_q == scope_pkg::CAP_FILL) || (state_q == scope_pkg::CAP_ARMED));

//--------------------------------------
// Next state

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      scope_pkg::CAP_FILL:
        if (time_stop)
          state_d = scope_pkg::CAP_DONE;
        else if (wr_addr_q >= i_cfg.pretrigger)
          state_d = scope_pkg::CAP_ARMED;        // Pretrigger region written
      scope_pkg::CAP_ARMED:
        if (hit_take)
          state_d = scope_pkg::CAP_POST;
        else if (time_stop)
          state_d = scope_pkg::CAP_DONE;
      scope_pkg::CAP_POST:
        if (post_next >= post_target)
          state_d = scope_pkg::CAP_DONE;         // Last post-trigger sample this cycle
      default:
        state_d = state_q;                       // Done holds until reset
    endcase
  end

//--------------------------------------
// Counters and trigger capture

  always_ff @(posedge sample_write_clock)
  begin
    if (sample_system_reset)
    begin
      state_q     <= scope_pkg::CAP_FILL;
      wr_addr_q   <= '0;
      tb_cnt_q    <= '0;
      post_cnt_q  <= '0;
      triggered_q <= 1'b0;
      trig_addr_q <= '0;
    end
    else
    begin
      state_q <= state_d;
      if (state_q != scope_pkg::CAP_DONE)
      begin
        wr_addr_q <= wr_addr_q + 1'b1;           // Wraps at 8192
        tb_cnt_q  <= tb_cnt_q + 1'b1;
      end
      if (hit_take)
      begin
        triggered_q <= 1'b1;
        trig_addr_q <= i_hit_addr;
        post_cnt_q  <= scope_pkg::addr_t'(1);    // Sample written alongside the hit
      end
      else if (state_q == scope_pkg::CAP_POST)
        post_cnt_q <= post_next;
      else if (time_stop)
        trig_addr_q <= i_cfg.pretrigger;         // Auto mode shows the buffer as is
    end
  end

  assign o_wr_en   = state_q != scope_pkg::CAP_DONE;
  assign o_wr_addr = wr_addr_q;

  assign o_status.done            = state_q == scope_pkg::CAP_DONE;
  assign o_status.triggered       = triggered_q;
  assign o_status.trigger_address = trig_addr_q;

  // A finished capture stays frozen until the next reset
  a_done_frozen: assert property (
    @(posedge sample_write_clock) disable iff (sample_system_reset)
    (state_q == scope_pkg::CAP_DONE) |=> $stable(wr_addr_q) && $stable(o_status)
  ) else $error("Capture moved on after done");

  // Once triggered the FSM never returns to fill or armed
  a_trig_sticky: assert property (
    @(posedge sample_write_clock) disable iff (sample_system_reset)
    triggered_q |=> triggered_q &&
                    ((state_q == scope_pkg::CAP_POST) || (state_q == scope_pkg::CAP_DONE))
  ) else $error("Triggered flag fell before a reset");

endmodule

/* hdl/readback_port.sv */
//--------------------------------------
// Byte readback of the sample memory with valid/ready handshakes
// One read in flight, offset steps by one after each accepted request
//--------------------------------------
`timescale 1ns/100ps

module readback_port
(
  input  logic                              sample_write_clock,
  input  logic                              sample_system_reset,
  input  logic                              i_offset_load,
  input  scope_pkg::addr_t                  i_offset_value,
  input  logic [1:0]                        i_byte_select,
  input  logic                              i_rd_req_valid,
  output logic                              o_rd_req_ready,
  output logic                              o_rd_resp_valid,
  input  logic                              i_rd_resp_ready,
  output logic [scope_pkg::SAMPLE_BITS-1:0] o_rd_data,
  output logic                              o_mem_rd_en,
  output scope_pkg::addr_t                  o_mem_rd_addr,
  input  scope_pkg::adc_sample_t            i_mem_rd_data
);

  scope_pkg::addr_t offset_q;
  logic             resp_valid_q;
  logic [1:0]       sel_q;         // Byte lane latched with the request
  logic             accept;

  assign o_rd_req_ready = !resp_valid_q;   // Blocked while a response waits
  assign accept         = i_rd_req_valid && o_rd_req_ready;

  assign o_mem_rd_en   = accept;
  assign o_mem_rd_addr = offset_q;

  always_ff @(posedge sample_write_clock)
  begin
    if (sample_system_reset)
    begin
      offset_q     <= '0;
      resp_valid_q <= 1'b0;
    end
    else
    begin
      if (i_offset_load)
        offset_q <= i_offset_value;        // Host load wins over the step
      else if (accept)
        offset_q <= offset_q + 1'b1;
      if (accept)
        resp_valid_q <= 1'b1;              // Memory data lands next cycle
      else if (i_rd_resp_ready)
        resp_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge sample_write_clock)
  begin
    if (accept)
      sel_q <= i_byte_select;
  end

//--------------------------------------
// Byte select

  always_comb
  begin
    case (sel_q)
      2'd0:    o_rd_data = i_mem_rd_data.ch1_a;
      2'd1:    o_rd_data = i_mem_rd_data.ch1_b;
      2'd2:    o_rd_data = i_mem_rd_data.ch2_a;
      default: o_rd_data = i_mem_rd_data.ch2_b;
    endcase
  end

  assign o_rd_resp_valid = resp_valid_q;

  // Relies on the memory holding its read word while no new read is issued
  a_resp_hold: assert property (
    @(posedge sample_write_clock) disable iff (sample_system_reset)
    (o_rd_resp_valid && !i_rd_resp_ready) |=> o_rd_resp_valid && $stable(o_rd_data)
  ) else $error("Read response changed under back-pressure");

endmodule

/* hdl/scope_capture_top.sv */
//--------------------------------------
// Top of the sample capture engine
// Connects settings, memory, trigger, capture FSM and readback
//--------------------------------------
`timescale 1ns/100ps

module scope_capture_top
(
  input  logic                              sample_write_clock,
  input  logic                              sample_system_reset,
  input  scope_pkg::cmd_t                   i_cmd,
  input  logic                              i_cmd_valid,
  input  scope_pkg::adc_sample_t            i_sample,          // New sample every clock
  input  logic                              i_rd_req_valid,
  output logic                              o_rd_req_ready,
  output logic                              o_rd_resp_valid,
  input  logic                              i_rd_resp_ready,
  output logic [scope_pkg::SAMPLE_BITS-1:0] o_rd_data,
  output scope_pkg::capture_status_t        o_status
);

  scope_pkg::capture_cfg_t cfg;
  logic                    offset_load;
  scope_pkg::addr_t        offset_value;
  logic                    wr_en;
  scope_pkg::addr_t        wr_addr;
  logic                    hit;
  scope_pkg::addr_t        hit_addr;
  logic                    mem_rd_en;
  scope_pkg::addr_t        mem_rd_addr;
  scope_pkg::adc_sample_t  mem_rd_data;

  scope_config_regs u_cfg (
    .sample_write_clock (sample_write_clock), .sample_system_reset (sample_system_reset),
    .i_cmd (i_cmd), .i_cmd_valid (i_cmd_valid), .o_cfg (cfg),
    .o_offset_load (offset_load), .o_offset_value (offset_value)
  );

  // Write data comes straight from the ADC inputs
  sample_ram u_ram (
    .sample_write_clock (sample_write_clock),
    .i_wr_en (wr_en), .i_wr_addr (wr_addr), .i_wr_data (i_sample),
    .i_rd_en (mem_rd_en), .i_rd_addr (mem_rd_addr), .o_rd_data (mem_rd_data)
  );

  trigger_detector u_trig (
    .sample_write_clock (sample_write_clock), .sample_system_reset (sample_system_reset),
    .i_sample (i_sample), .i_wr_addr (wr_addr), .i_cfg (cfg),
    .o_hit (hit), .o_hit_addr (hit_addr)
  );

  capture_control u_ctrl (
    .sample_write_clock (sample_write_clock), .sample_system_reset (sample_system_reset),
    .i_cfg (cfg), .i_hit (hit), .i_hit_addr (hit_addr),
    .o_wr_en (wr_en), .o_wr_addr (wr_addr), .o_status (o_status)
  );

  readback_port u_read (
    .sample_write_clock (sample_write_clock), .sample_system_reset (sample_system_reset),
    .i_offset_load (offset_load), .i_offset_value (offset_value),
    .i_byte_select (cfg.byte_select),
    .i_rd_req_valid (i_rd_req_valid), .o_rd_req_ready (o_rd_req_ready),
    .o_rd_resp_valid (o_rd_resp_valid), .i_rd_resp_ready (i_rd_resp_ready),
    .o_rd_data (o_rd_data),
    .o_mem_rd_en (mem_rd_en), .o_mem_rd_addr (mem_rd_addr), .i_mem_rd_data (mem_rd_data)
  );

endmodule

/* sim/tb_scope_tasks.svh */
//--------------------------------------
// Tasks of the capture testbench, included inside its top module
// Reset and setup, commands, timed waits, reads and the per-test report
//--------------------------------------

  // Hands a wait that gave up to the timeout exit, this process stops here
  task automatic abort_run(input string why);
    $display("Timeout: %s", why);
    aborted = 1'b1;
    wait (!aborted);
  endtask

  task automatic expect_equal(input string what, input int got, input int exp);
    assert (got == exp)
    else
    begin
      errors++;
      $display("Mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  // Four reset cycles, returns once the first sample after reset is on the bus
  task automatic restart();
    int t;
    rst_cycles = 4;
    t = 0;
    do
    begin
      @(posedge sample_write_clock);
      #3;                                   // After the stream driver
      t++;
    end
    while ((rst_cycles != 0 || sample_system_reset) && t < WAIT_LIMIT);
    if (sample_system_reset)
      abort_run("reset was never released");
  endtask

  task automatic send_cmd(input scope_pkg::cmd_opcode_e op, input logic [31:0] data);
    @(posedge sample_write_clock);
    #2;
    i_cmd.opcode = op;
    i_cmd.data   = data;
    i_cmd_valid  = 1'b1;
    @(posedge sample_write_clock);
    #2;
    i_cmd_valid = 1'b0;
  endtask

  // All settings land well before the pretrigger region is full
  task automatic setup_capture(input int pre, input int total, input logic [31:0] timebase,
                               input int level, input bit fall, input bit ch2,
                               input bit normal);
    restart();
    send_cmd(scope_pkg::CMD_PRETRIGGER, 32'(pre));
    send_cmd(scope_pkg::CMD_TOTAL, 32'(total));
    send_cmd(scope_pkg::CMD_TIMEBASE, timebase);
    send_cmd(scope_pkg::CMD_TRIG_LEVEL, 32'(level));
    send_cmd(scope_pkg::CMD_TRIG_EDGE, 32'(fall));
    send_cmd(scope_pkg::CMD_TRIG_CHANNEL, 32'(ch2));
    send_cmd(scope_pkg::CMD_TRIG_MODE, 32'(normal));
  endtask

  // Polls done each cycle, gives back the last address written
  task automatic wait_done(output int last);
    int t;
    t = 0;
    do
    begin
      @(posedge sample_write_clock);
      #1;
      t++;
    end
    while (!o_status.done && t < WAIT_LIMIT);
    if (!o_status.done)
      abort_run("capture never reported done");
    last = n - 1;                           // n is one past the last sample clocked in
  endtask

  task automatic watch_quiet(input int cycles, output bit seen);
    seen = 1'b0;
    repeat (cycles)
    begin
      @(posedge sample_write_clock);
      #1;
      if (o_status.done || o_status.triggered)
        seen = 1'b1;
    end
  endtask

  // One read, with hold cycles of back-pressure before the response is taken
  task automatic read_byte(input int hold, output logic [7:0] data);
    int t;
    @(posedge sample_write_clock);
    #2;
    i_rd_req_valid  = 1'b1;
    i_rd_resp_ready = 1'b0;
    t = 0;
    while (!o_rd_req_ready && t < WAIT_LIMIT)
    begin
      @(posedge sample_write_clock);
      #2;
      t++;
    end
    if (!o_rd_req_ready)
      abort_run("read request was never accepted");
    @(posedge sample_write_clock);          // Request taken on this edge
    #2;
    i_rd_req_valid = 1'b0;
    expect_equal("response valid after accept", int'(o_rd_resp_valid), 1);
    data = o_rd_data;
    repeat (hold)
    begin
      @(posedge sample_write_clock);
      #2;
      expect_equal("held read data", int'(o_rd_data), int'(data));
      expect_equal("request ready while held", int'(o_rd_req_ready), 0);
    end
    i_rd_resp_ready = 1'b1;
    @(posedge sample_write_clock);
    #2;
    i_rd_resp_ready = 1'b0;
  endtask

  task automatic report_test(input string name, input int err_mark);
    tests_run++;
    if (errors != err_mark)
    begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, errors - err_mark);
    end
    else
      $display("test %s: ok", name);
  endtask

/* sim/tb_scope_capture.sv */
//--------------------------------------
// Testbench of the sample capture engine
// Streams one known sample per cycle and runs the trigger, timeout and readback tests
// Built and run through the Makefile, ends with one pass or fail line
//--------------------------------------
`timescale 1ns/100ps

module tb_scope_capture;

  localparam int WAIT_LIMIT = 5000;     // Cycles before any wait gives up

  logic                              sample_write_clock;
  logic                              sample_system_reset;
  scope_pkg::cmd_t                   i_cmd;
  logic                              i_cmd_valid;
  scope_pkg::adc_sample_t            i_sample;
  logic                              i_rd_req_valid;
  logic                              o_rd_req_ready;
  logic                              o_rd_resp_valid;
  logic                              i_rd_resp_ready;
  logic [scope_pkg::SAMPLE_BITS-1:0] o_rd_data;
  scope_pkg::capture_status_t        o_status;

  int          errors;
  int          tests_run;
  int          tests_failed;
  int          rst_cycles;              // Reset cycles still to drive
  int          n;                       // Next sample index, equal to its write address
  int          seed;
  bit          aborted;                 // Set by a wait that ran out of cycles
  logic [31:0] rand_tab [scope_pkg::BUFFER_SIZE];

//--------------------------------------
// Sample model

  // A bytes ramp, up on channel 1 and down on channel 2, flat from index 800
  function automatic scope_pkg::adc_sample_t sample_at(input int idx);
    scope_pkg::adc_sample_t s;
    int                     r;
    r = idx >> 2;
    if (r > 200)
      r = 200;
    s.ch1_a = 8'(r);
    s.ch2_a = 8'(255 - r);
    s.ch1_b = rand_tab[scope_pkg::addr_t'(idx)][7:0];    // Random lanes per address
    s.ch2_b = rand_tab[scope_pkg::addr_t'(idx)][15:8];
    return s;
  endfunction

  function automatic logic [7:0] lane_of(input scope_pkg::adc_sample_t s, input int sel);
    case (sel)
      0:       return s.ch1_a;
      1:       return s.ch1_b;
      2:       return s.ch2_a;
      default: return s.ch2_b;
    endcase
  endfunction

  // First address from start on where the chosen A byte crosses level
  function automatic int find_crossing(input int start, input int level, input bit fall,
                                       input bit ch2);
    int prev;
    int cur;
    for (int a = start; a < scope_pkg::BUFFER_SIZE; a++)
    begin
      prev = int'(lane_of(sample_at(a - 1), ch2 ? 2 : 0));
      cur  = int'(lane_of(sample_at(a), ch2 ? 2 : 0));
      if (fall ? (prev >= level && cur < level) : (prev < level && cur >= level))
        return a;
    end
    return -1;
  endfunction

  `include "tb_scope_tasks.svh"

  scope_capture_top dut_i (
    .sample_write_clock  (sample_write_clock),
    .sample_system_reset (sample_system_reset),
    .i_cmd               (i_cmd),
    .i_cmd_valid         (i_cmd_valid),
    .i_sample            (i_sample),
    .i_rd_req_valid      (i_rd_req_valid),
    .o_rd_req_ready      (o_rd_req_ready),
    .o_rd_resp_valid     (o_rd_resp_valid),
    .i_rd_resp_ready     (i_rd_resp_ready),
    .o_rd_data           (o_rd_data),
    .o_status            (o_status)
  );

  initial
  begin
    sample_write_clock = 1'b0;
    forever #20 sample_write_clock = ~sample_write_clock;   // 40 ns period
  end

//--------------------------------------
// Reset and sample stream, 2 ns after each rising edge

  initial
  begin
    seed                = 32'h8c88_4200;
    sample_system_reset = 1'b1;
    rst_cycles          = 4;
    n                   = 0;
    i_cmd.opcode        = scope_pkg::CMD_PRETRIGGER;
    i_cmd.data          = 32'd0;
    i_cmd_valid         = 1'b0;
    i_rd_req_valid      = 1'b0;
    i_rd_resp_ready     = 1'b0;
    for (int i = 0; i < scope_pkg::BUFFER_SIZE; i++)
      rand_tab[scope_pkg::addr_t'(i)] = $random(seed);
    i_sample = sample_at(0);
    forever
    begin
      @(posedge sample_write_clock);
      #2;
      if (rst_cycles > 0)
      begin
        sample_system_reset = 1'b1;
        rst_cycles--;
        n = 0;                          // Address 0 is the first sample after reset
      end
      else
        sample_system_reset = 1'b0;
      i_sample = sample_at(n);
      if (!sample_system_reset)
        n++;
    end
  end

//--------------------------------------
// Concurrent checks

  // Back-pressure keeps the byte and blocks a second read
  a_resp_hold: assert property (
    @(posedge sample_write_clock) disable iff (sample_system_reset)
    (o_rd_resp_valid && !i_rd_resp_ready) |=> $stable(o_rd_data) && !o_rd_req_ready
  ) else
  begin
    errors++;
    $display("Mismatch at %0t: read response moved under back-pressure", $time);
  end

  a_one_read: assert property (
    @(posedge sample_write_clock) disable iff (sample_system_reset)
    o_rd_resp_valid |-> !o_rd_req_ready
  ) else
  begin
    errors++;
    $display("Mismatch at %0t: request ready while a response waits", $time);
  end

  a_done_holds: assert property (
    @(posedge sample_write_clock) disable iff (sample_system_reset)
    o_status.done |=> o_status.done
  ) else
  begin
    errors++;
    $display("Mismatch at %0t: done fell without a reset", $time);
  end

  a_trig_holds: assert property (
    @(posedge sample_write_clock) disable iff (sample_system_reset)
    o_status.triggered |=> o_status.triggered
  ) else
  begin
    errors++;
    $display("Mismatch at %0t: triggered fell without a reset", $time);
  end

//--------------------------------------
// Timeout exit

  initial
  begin
    wait (aborted);
    $display(">>> FAIL");
    $finish;
  end

//--------------------------------------
// Test sequence

  initial
  begin
    logic [7:0] got;
    bit         seen;
    int         trig;
    int         last;
    int         err_mark;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;

    // Rising edge on channel 1, level 100, normal mode
    err_mark = errors;
    setup_capture(100, 300, 32'hFFFF_FFFF, 100, 1'b0, 1'b0, 1'b1);
    trig = find_crossing(100, 100, 1'b0, 1'b0);
    wait_done(last);
    expect_equal("triggered", int'(o_status.triggered), 1);
    expect_equal("trigger address", int'(o_status.trigger_address), trig);
    expect_equal("last written address", last, trig + 300 - 100);
    report_test("rising trigger, normal mode", err_mark);

    // Readback around the trigger, ch1_b lane
    err_mark = errors;
    send_cmd(scope_pkg::CMD_READ_SELECT, 32'd1);
    send_cmd(scope_pkg::CMD_READ_OFFSET, 32'(trig - 2));
    for (int i = 0; i < 4; i++)
    begin
      read_byte(0, got);
      expect_equal("read byte", int'(got), int'(lane_of(sample_at(trig - 2 + i), 1)));
    end
    report_test("readback", err_mark);

    // Held response on the ch2_b lane, then the following address
    err_mark = errors;
    send_cmd(scope_pkg::CMD_READ_SELECT, 32'd3);
    read_byte(6, got);
    expect_equal("held read byte", int'(got), int'(lane_of(sample_at(trig + 2), 3)));
    read_byte(0, got);
    expect_equal("read after release", int'(got), int'(lane_of(sample_at(trig + 3), 3)));
    report_test("back-pressure", err_mark);

    // Falling edge on channel 2, level 60
    err_mark = errors;
    setup_capture(100, 300, 32'hFFFF_FFFF, 60, 1'b1, 1'b1, 1'b1);
    trig = find_crossing(100, 60, 1'b1, 1'b1);
    wait_done(last);
    expect_equal("triggered", int'(o_status.triggered), 1);
    expect_equal("trigger address", int'(o_status.trigger_address), trig);
    expect_equal("last written address", last, trig + 300 - 100);
    report_test("falling trigger, channel 2", err_mark);

    // Level above the ramp, auto mode stops on the time base
    err_mark = errors;
    setup_capture(100, 300, 32'd200, 250, 1'b0, 1'b0, 1'b0);
    wait_done(last);
    expect_equal("triggered", int'(o_status.triggered), 0);
    expect_equal("trigger address", int'(o_status.trigger_address), 100);
    report_test("auto timeout", err_mark);

    // Same level in normal mode never stops
    err_mark = errors;
    setup_capture(100, 300, 32'd200, 250, 1'b0, 1'b0, 1'b1);
    watch_quiet(400, seen);
    expect_equal("done or triggered seen", int'(seen), 0);
    report_test("normal mode without trigger", err_mark);

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0 && tests_failed == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

/* tb.f */
+incdir+sim
hdl/scope_pkg.sv
hdl/scope_config_regs.sv
hdl/sample_ram.sv
hdl/trigger_detector.sv
hdl/capture_control.sv
hdl/readback_port.sv
hdl/scope_capture_top.sv
sim/tb_scope_capture.sv

/* Makefile */
# Verilator build and run of the capture engine testbench
# Override any variable on the command line, e.g. make LOG=run.log

VERILATOR  ?= verilator
TOP        ?= tb_scope_capture
FILELIST   ?= tb.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
JOBS       ?= 0
VFLAGS     ?= --binary --timing --assert -j $(JOBS)
LINT_FLAGS ?= --lint-only --timing --assert
FAIL_MSG   ?= >>> FAIL

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q -F -- '$(FAIL_MSG)' $(LOG); then \
	  echo "simulation failed, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
